// File: run.sh
#!/bin/sh
# builds and runs the vector execute stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
        --top-module tb_vex_datapath -o tb_vex_datapath > build.log 2>&1; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_vex_datapath > "$log" 2>&1
status=$?
cat "$log"

if grep -q "RESULT: FAIL" "$log"; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: tests/tb_vex_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vex_datapath import vex_pkg::*; ();

    localparam int max_wait = 20;

    logic    CLK;
    logic    rst;
    logic    issue_valid;
    vissue_t vctrls;
    word_t   rdat1;
    word_t   rdat2;
    logic    wb_valid;
    vwb_t    vwb_ctrls;
    logic    res_valid;
    vexmem_t vmem_in;

    logic [127:0] model [32];    // mirror of the register file.
    logic [31:0]  lfsr = 32'hd07cc81a;
    int           checks = 0;

    vex_datapath uut (
        .CLK(CLK), .rst(rst), .issue_valid(issue_valid), .vctrls(vctrls),
        .rdat1(rdat1), .rdat2(rdat2), .wb_valid(wb_valid), .vwb_ctrls(vwb_ctrls),
        .res_valid(res_valid), .vmem_in(vmem_in)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];    // taps 32 22 2 1.
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t extend(input word_t x, input int width, input logic sx);
        word_t m;
        m = 32'hffff_ffff >> (32 - width);
        if (sx && x[width-1])
            return x | ~m;
        return x & m;
    endfunction

    // element e of a register sits at bit e*width.
    function automatic word_t element(input logic [4:0] r, input int width, input int e,
                                      input logic sx);
        logic [127:0] t;
        t = model[r] >> (e * width);
        return extend(t[31:0], width, sx);
    endfunction

    function automatic vexmem_t expected(input vissue_t c, input word_t rd1, input word_t rd2);
        vexmem_t res;
        int      width;
        int      e;
        word_t   m, a, b, sh, r;
        logic    mbit, en;
        width = 8 << int'(c.veew);
        m     = 32'hffff_ffff >> (32 - width);
        res   = '0;
        for (int k = 0; k < num_lanes; k++) begin
            e = 4 * int'(c.vuop_num) + k;
            a = c.use_rs2 ? rd2 : element(c.vs2_sel, width, e, c.vsignext);
            if (c.use_imm)
                b = extend({27'b0, c.vimm}, 5, c.vsignext);
            else if (c.use_rs1)
                b = extend(rd1, width, c.vsignext);
            else
                b = element(c.vs1_sel, width, e, c.vsignext);
            sh   = b & 32'(width - 1);
            mbit = model[0][e];
            en   = c.vlaneactive[k] & (~c.vmask_en | mbit);
            case (c.vexec)
                vadd:    r = a + b;
                vsub:    r = a - b;
                vand:    r = a & b;
                vor:     r = a | b;
                vxor:    r = a ^ b;
                vsll:    r = a << sh;
                vsrl:    r = (a & m) >> sh;
                vsra:    r = $signed(extend(a, width, 1'b1)) >>> sh;
                vmin:    r = ($signed(a) < $signed(b)) ? a : b;
                vminu:   r = (a < b) ? a : b;
                vmax:    r = ($signed(a) > $signed(b)) ? a : b;
                vmaxu:   r = (a > b) ? a : b;
                vmerge:  r = mbit ? b : a;
                default: r = '0;
            endcase
            res.valu_res[k]   = en ? (r & m) : '0;
            res.vlane_mask[k] = en;
        end
        res.vd_sel   = c.vd_sel;
        res.veew     = c.veew;
        res.vuop_num = c.vuop_num;
        return res;
    endfunction

    function automatic vissue_t rand_ctrl(input vop_t op, input sew_t sew);
        vissue_t c;
        c             = '0;
        c.vs1_sel     = 5'(rand_bits(5));
        c.vs2_sel     = 5'(rand_bits(5));
        c.vd_sel      = 5'(rand_bits(5));
        c.veew        = sew;
        c.vuop_num    = (sew == sew8)  ? 2'(rand_bits(2)) :
                        (sew == sew16) ? 2'(rand_bits(1)) : 2'd0;
        c.vexec       = op;
        c.vimm        = 5'(rand_bits(5));
        c.vsignext    = rand_bits(1) != 0;
        c.vlaneactive = 4'hf;
        return c;
    endfunction

    function automatic vop_t rand_op();
        return vop_t'(4'(rand_bits(4) % 13));
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "testbench stopped at the first failure");
    endtask

    task automatic drive_write(input logic [4:0] r, input logic [127:0] data,
                               input logic [15:0] be);
        wb_valid            = 1'b1;
        vwb_ctrls.vd        = r;
        vwb_ctrls.vwdata    = data;
        vwb_ctrls.vbyte_wen = be;
        for (int i = 0; i < 16; i++) begin
            if (be[i])
                model[r][8*i +: 8] = data[8*i +: 8];
        end
    endtask

    task automatic write_reg(input logic [4:0] r, input logic [127:0] data,
                             input logic [15:0] be);
        drive_write(r, data, be);
        @(negedge CLK);
        wb_valid = 1'b0;
    endtask

    task automatic drive_issue(input vissue_t c, input word_t rd1, input word_t rd2);
        issue_valid = 1'b1;
        vctrls      = c;
        rdat1       = rd1;
        rdat2       = rd2;
    endtask

    // called one falling edge after the issue.
    task automatic collect(input vexmem_t exp);
        int cycles;
        cycles = 1;
        while (!res_valid) begin
            if (cycles >= max_wait)
                stop_with_failure($sformatf("timeout: res_valid never rose after %0d cycles",
                                            cycles));
            @(negedge CLK);
            cycles++;
        end
        assert (cycles == 1)
            else stop_with_failure($sformatf("ERROR at %0t: result %0d cycles after issue",
                                             $time, cycles));
        for (int k = 0; k < num_lanes; k++) begin
            assert (vmem_in.valu_res[k] == exp.valu_res[k])
                else stop_with_failure($sformatf("ERROR at %0t: lane %0d got %h, expected %h",
                                                 $time, k, vmem_in.valu_res[k],
                                                 exp.valu_res[k]));
        end
        assert (vmem_in == exp)
            else stop_with_failure($sformatf("ERROR at %0t: result %h, expected %h",
                                             $time, vmem_in, exp));
        checks++;
    endtask

    task automatic run_op(input vissue_t c, input word_t rd1, input word_t rd2);
        vexmem_t exp;
        exp = expected(c, rd1, rd2);
        drive_issue(c, rd1, rd2);
        @(negedge CLK);
        issue_valid = 1'b0;
        collect(exp);
    endtask

    task automatic read_back(input logic [4:0] r);
        vissue_t c;
        c         = rand_ctrl(vadd, sew32);
        c.vs2_sel = r;
        c.use_imm = 1'b1;
        c.vimm    = 5'd0;
        run_op(c, '0, '0);
    endtask

    task automatic reset_and_writeback();
        logic [4:0]  r;
        logic [15:0] be;
        for (int i = 0; i < 3; i++) begin
            assert (res_valid == 1'b0)
                else stop_with_failure($sformatf("ERROR at %0t: res_valid high after reset",
                                                 $time));
            @(negedge CLK);
        end
        for (int i = 0; i < 4; i++)
            read_back(5'(rand_bits(5)));
        for (int i = 0; i < 32; i++)
            write_reg(5'(i), {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)}, '1);
        for (int i = 0; i < 12; i++) begin
            r = 5'(rand_bits(5));
            for (int g = 0; g < num_lanes; g++) begin
                be[4*g +: 4] = 4'(rand_bits(4));
                if (be[4*g +: 4] == 4'b0000)
                    be[4*g +: 4] = 4'b1000;    // every bank needs one enabled byte.
            end
            write_reg(r, {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)}, be);
            read_back(r);
        end
    endtask

    task automatic all_ops_sew32();
        for (int op = 0; op < 13; op++) begin
            for (int i = 0; i < 3; i++)
                run_op(rand_ctrl(vop_t'(4'(op)), sew32), '0, '0);
        end
    endtask

    task automatic narrow_element_select();
        vissue_t c;
        for (int s = 0; s < 2; s++) begin
            for (int u = 0; u < (s == 0 ? 4 : 2); u++) begin
                for (int sx = 0; sx < 2; sx++) begin
                    for (int i = 0; i < 3; i++) begin
                        c          = rand_ctrl(rand_op(), sew_t'(2'(s)));
                        c.vuop_num = 2'(u);
                        c.vsignext = sx != 0;
                        run_op(c, '0, '0);
                    end
                end
            end
        end
    endtask

    task automatic scalar_and_imm_operands();
        vissue_t c;
        for (int s = 0; s < 3; s++) begin
            for (int sel = 1; sel < 8; sel++) begin
                c         = rand_ctrl(rand_op(), sew_t'(2'(s)));
                c.use_imm = sel[0];
                c.use_rs1 = sel[1];
                c.use_rs2 = sel[2];
                run_op(c, rand_bits(32), rand_bits(32));
            end
        end
    endtask

    task automatic lane_masking();
        vissue_t c;
        write_reg(5'd0, {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)}, '1);
        for (int i = 0; i < 16; i++) begin
            c             = rand_ctrl(rand_op(), sew_t'(2'(rand_bits(32) % 3)));
            c.vmask_en    = rand_bits(1) != 0;
            c.vlaneactive = 4'(rand_bits(4));
            run_op(c, '0, '0);
        end
        for (int u = 0; u < 4; u++) begin
            c          = rand_ctrl(vmerge, sew8);
            c.vuop_num = 2'(u);
            run_op(c, '0, '0);
        end
    endtask

    // issue a shares its cycle with the write and issue b follows.
    task automatic back_to_back_issue();
        vissue_t c;
        vexmem_t exp_a;
        vexmem_t exp_b;
        c     = rand_ctrl(vxor, sew32);
        c.vs2_sel = c.vs1_sel + 5'd1;    // keeps the two sources apart.
        exp_a = expected(c, '0, '0);
        drive_issue(c, '0, '0);
        drive_write(c.vs1_sel, {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)}, '1);
        exp_b = expected(c, '0, '0);
        @(negedge CLK);
        wb_valid = 1'b0;
        drive_issue(c, '0, '0);
        collect(exp_a);
        @(negedge CLK);
        issue_valid = 1'b0;
        collect(exp_b);
    endtask

    initial begin
        rst         = 1'b1;
        issue_valid = 1'b0;
        vctrls      = '0;
        rdat1       = '0;
        rdat2       = '0;
        wb_valid    = 1'b0;
        vwb_ctrls   = '0;
        for (int i = 0; i < 32; i++)
            model[i] = '0;
        repeat (10) @(negedge CLK);
        rst = 1'b0;
        reset_and_writeback();
        all_ops_sew32();
        narrow_element_select();
        scalar_and_imm_operands();
        lane_masking();
        back_to_back_issue();
        $display("%0d results checked", checks);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/ex_result_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_result_reg import vex_pkg::*; (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  issue_valid,
    input  word_t [num_lanes-1:0] lane_res,
    input  logic [num_lanes-1:0]  lane_mask,
    input  vissue_t               vctrls,
    output logic                  res_valid,
    output vexmem_t               vmem_in
);

    always_ff @(posedge CLK) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_valid) begin
            for (int k = 0; k < num_lanes; k++) begin
                vmem_in.valu_res[k] <= lane_mask[k] ? lane_res[k] : '0;    // off lanes read zero.
            end
            vmem_in.vlane_mask <= lane_mask;
            vmem_in.vd_sel     <= vctrls.vd_sel;
            vmem_in.veew       <= vctrls.veew;
            vmem_in.vuop_num   <= vctrls.vuop_num;
        end
    end

    a_idle_after_rst: assert property (@(posedge CLK) rst |=> !res_valid)
        else $error("ex_result_reg: res_valid high right after reset");

endmodule

`default_nettype wire

// File: verilog/mask_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mask_unit import vex_pkg::*; (
    input  logic [127:0]          v0,
    input  logic                  mask_enable,
    input  logic [1:0]            uop_num,
    input  logic [num_lanes-1:0]  lane_active,
    output logic [num_lanes-1:0]  mask_bits,
    output logic [num_lanes-1:0]  lane_mask
);

    always_comb begin
        logic [3:0] e;
        for (int k = 0; k < num_lanes; k++) begin
            e            = {uop_num, 2'(k)};
            mask_bits[k] = v0[e];        // one v0 bit per element.
            lane_mask[k] = lane_active[k] & (~mask_enable | mask_bits[k]);
        end
    end

endmodule

`default_nettype wire

// File: verilog/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select import vex_pkg::*; (
    input  word_t [num_lanes-1:0] xdat1,
    input  word_t [num_lanes-1:0] xdat2,
    input  word_t                 rdat1,
    input  word_t                 rdat2,
    input  vissue_t               vctrls,
    output word_t [num_lanes-1:0] opa,
    output word_t [num_lanes-1:0] opb
);

    word_t ext_imm;
    word_t ext_rs1;

    assign ext_imm = vctrls.vsignext ? {{27{vctrls.vimm[4]}}, vctrls.vimm}
                                     : {27'b0, vctrls.vimm};

    // scalar cut to the element width.
    always_comb begin
        case (vctrls.veew)
            sew8: begin
                ext_rs1 = vctrls.vsignext ? {{24{rdat1[7]}}, rdat1[7:0]} : {24'b0, rdat1[7:0]};
            end
            sew16: begin
                ext_rs1 = vctrls.vsignext ? {{16{rdat1[15]}}, rdat1[15:0]}
                                          : {16'b0, rdat1[15:0]};
            end
            default: begin
                ext_rs1 = rdat1;
            end
        endcase
    end

    always_comb begin
        for (int k = 0; k < num_lanes; k++) begin
            if (vctrls.use_imm) begin
                opb[k] = ext_imm;
            end else if (vctrls.use_rs1) begin
                opb[k] = ext_rs1;
            end else begin
                opb[k] = xdat1[k];
            end
            opa[k] = vctrls.use_rs2 ? rdat2 : xdat2[k];    // broadcast.
        end
    end

endmodule

`default_nettype wire

// File: verilog/read_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module read_xbar import vex_pkg::*; (
    input  word_t [num_lanes-1:0] bank_dat,
    input  sew_t                  veew,
    input  logic [1:0]            uop_num,
    input  logic                  sign_ext,
    output word_t [num_lanes-1:0] out_dat
);

    always_comb begin
        logic [3:0]  e;
        logic [15:0] half;
        logic [7:0]  bsel;
        for (int k = 0; k < num_lanes; k++) begin
            e    = {uop_num, 2'(k)};                   // element index.
            half = bank_dat[e[2:1]][16*e[0] +: 16];
            bsel = bank_dat[uop_num][8*k +: 8];     // sew8 bank equals the micro-op.
            case (veew)
                sew8: begin
                    out_dat[k] = sign_ext ? {{24{bsel[7]}}, bsel} : {24'b0, bsel};
                end
                sew16: begin
                    out_dat[k] = sign_ext ? {{16{half[15]}}, half} : {16'b0, half};
                end
                default: begin
                    out_dat[k] = bank_dat[k];
                end
            endcase
        end
        a_uop_range: assert (veew == sew8 || uop_num == 2'd0 ||
                             (veew == sew16 && uop_num == 2'd1))
            else $error("read_xbar: uop_num %0d illegal for sew %0d", uop_num, veew);
    end

endmodule

`default_nettype wire

// File: verilog/vector_bank.sv
`timescale 1ns/1ps
`default_nettype none

module vector_bank import vex_pkg::*; (
    input  logic       CLK,
    input  logic       rst,
    input  logic [4:0] vs1,
    input  logic [4:0] vs2,
    input  logic       wen,
    input  logic [4:0] vw,
    input  word_t      vwdata,
    input  logic [3:0] byte_wen,
    output word_t      vdat1,
    output word_t      vdat2,
    output word_t      v0
);

    word_t regs [32];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_wen[b]) begin
                    regs[vw][8*b +: 8] <= vwdata[8*b +: 8];
                end
            end
        end
    end

    // a same-cycle issue sees the old word.
    assign vdat1 = regs[vs1];
    assign vdat2 = regs[vs2];
    assign v0    = regs[0];    // mask source for this slice.

    a_wen_has_bytes: assert property (@(posedge CLK) disable iff (rst)
        wen |-> byte_wen != 4'b0000)
        else $error("vector_bank: write strobe without byte enables");

endmodule

`default_nettype wire

// File: verilog/vex_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module vex_datapath import vex_pkg::*; (
    input  logic    CLK,
    input  logic    rst,
    input  logic    issue_valid,
    input  vissue_t vctrls,
    input  word_t   rdat1,
    input  word_t   rdat2,
    input  logic    wb_valid,
    input  vwb_t    vwb_ctrls,
    output logic    res_valid,
    output vexmem_t vmem_in
);

    logic [32*num_lanes-1:0] v0;
    word_t [num_lanes-1:0]   bankdat_src1, bankdat_src2;
    word_t [num_lanes-1:0]   xbardat_src1, xbardat_src2;
    word_t [num_lanes-1:0]   opa, opb;
    word_t [num_lanes-1:0]   lane_res;
    logic [num_lanes-1:0]    mask_bits, lane_mask;

    for (genvar k = 0; k < num_lanes; k++) begin : g_bank
        vector_bank u_bank (
            .CLK(CLK), .rst(rst),
            .vs1(vctrls.vs1_sel), .vs2(vctrls.vs2_sel),
            .wen(wb_valid), .vw(vwb_ctrls.vd),
            .vwdata(vwb_ctrls.vwdata[k]), .byte_wen(vwb_ctrls.vbyte_wen[k]),
            .vdat1(bankdat_src1[k]), .vdat2(bankdat_src2[k]),
            .v0(v0[32*k +: 32])
        );
    end

    read_xbar u_xbar_src1 (
        .bank_dat(bankdat_src1), .veew(vctrls.veew), .uop_num(vctrls.vuop_num),
        .sign_ext(vctrls.vsignext), .out_dat(xbardat_src1)
    );

    read_xbar u_xbar_src2 (
        .bank_dat(bankdat_src2), .veew(vctrls.veew), .uop_num(vctrls.vuop_num),
        .sign_ext(vctrls.vsignext), .out_dat(xbardat_src2)
    );

    operand_select u_opsel (
        .xdat1(xbardat_src1), .xdat2(xbardat_src2), .rdat1(rdat1), .rdat2(rdat2),
        .vctrls(vctrls), .opa(opa), .opb(opb)
    );

    for (genvar k = 0; k < num_lanes; k++) begin : g_lane
        vfu u_vfu (
            .vopa(opa[k]), .vopb(opb[k]), .mask_bit(mask_bits[k]),
            .vsew(vctrls.veew), .vop(vctrls.vexec), .vres(lane_res[k])
        );
    end

    mask_unit u_mask (
        .v0(v0), .mask_enable(vctrls.vmask_en), .uop_num(vctrls.vuop_num),
        .lane_active(vctrls.vlaneactive), .mask_bits(mask_bits), .lane_mask(lane_mask)
    );

    ex_result_reg u_res (
        .CLK(CLK), .rst(rst), .issue_valid(issue_valid), .lane_res(lane_res),
        .lane_mask(lane_mask), .vctrls(vctrls), .res_valid(res_valid), .vmem_in(vmem_in)
    );

endmodule

`default_nettype wire

// File: verilog/vex_pkg.sv
`default_nettype none

package vex_pkg;

    localparam int num_lanes = 4;

    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        sew8  = 2'd0,
        sew16 = 2'd1,
        sew32 = 2'd2
    } sew_t;

    typedef enum logic [3:0] {
        vadd   = 4'd0,
        vsub   = 4'd1,
        vand   = 4'd2,
        vor    = 4'd3,
        vxor   = 4'd4,
        vsll   = 4'd5,
        vsrl   = 4'd6,
        vsra   = 4'd7,
        vmin   = 4'd8,
        vminu  = 4'd9,
        vmax   = 4'd10,
        vmaxu  = 4'd11,
        vmerge = 4'd12
    } vop_t;

    typedef struct packed {
        logic [4:0]           vs1_sel;
        logic [4:0]           vs2_sel;
        logic [4:0]           vd_sel;
        sew_t                 veew;
        logic [1:0]           vuop_num;    // selects the group of four elements.
        vop_t                 vexec;
        logic [4:0]           vimm;
        logic                 vsignext;
        logic                 use_imm;
        logic                 use_rs1;
        logic                 use_rs2;
        logic                 vmask_en;
        logic [num_lanes-1:0] vlaneactive;
    } vissue_t;

    typedef struct packed {
        logic [4:0]                vd;
        word_t [num_lanes-1:0]     vwdata;
        logic [num_lanes-1:0][3:0] vbyte_wen;  // one group per bank.
    } vwb_t;

    typedef struct packed {
        word_t [num_lanes-1:0] valu_res;
        logic [num_lanes-1:0]  vlane_mask;
        logic [4:0]            vd_sel;
        sew_t                  veew;
        logic [1:0]            vuop_num;
    } vexmem_t;

endpackage

`default_nettype wire

// File: verilog/vfu.sv
`timescale 1ns/1ps
`default_nettype none

module vfu import vex_pkg::*; (
    input  word_t vopa,
    input  word_t vopb,
    input  logic  mask_bit,
    input  sew_t  vsew,
    input  vop_t  vop,
    output word_t vres
);

    word_t      wmask;
    word_t      sext_a;
    word_t      raw;
    logic [4:0] shamt;

    always_comb begin
        case (vsew)
            sew8: begin
                wmask  = 32'h0000_00ff;
                shamt  = {2'b00, vopb[2:0]};
                sext_a = {{24{vopa[7]}}, vopa[7:0]};
            end
            sew16: begin
                wmask  = 32'h0000_ffff;
                shamt  = {1'b0, vopb[3:0]};
                sext_a = {{16{vopa[15]}}, vopa[15:0]};
            end
            default: begin
                wmask  = 32'hffff_ffff;
                shamt  = vopb[4:0];
                sext_a = vopa;
            end
        endcase
    end

    always_comb begin
        unique case (vop)
            vadd:    raw = vopa + vopb;
            vsub:    raw = vopa - vopb;        // vs2 minus vs1.
            vand:    raw = vopa & vopb;
            vor:     raw = vopa | vopb;
            vxor:    raw = vopa ^ vopb;
            vsll:    raw = vopa << shamt;
            vsrl:    raw = (vopa & wmask) >> shamt;
            vsra:    raw = word_t'($signed(sext_a) >>> shamt);
            vmin:    raw = ($signed(vopa) < $signed(vopb)) ? vopa : vopb;
            vminu:   raw = (vopa < vopb) ? vopa : vopb;
            vmax:    raw = ($signed(vopa) > $signed(vopb)) ? vopa : vopb;
            vmaxu:   raw = (vopa > vopb) ? vopa : vopb;
            vmerge:  raw = mask_bit ? vopb : vopa;
            default: raw = '0;
        endcase
    end

    assign vres = raw & wmask;

endmodule

`default_nettype wire

// File: vlog.f
verilog/vex_pkg.sv
verilog/vector_bank.sv
verilog/read_xbar.sv
verilog/operand_select.sv
verilog/vfu.sv
verilog/mask_unit.sv
verilog/ex_result_reg.sv
verilog/vex_datapath.sv
tests/tb_vex_datapath.sv
